// ==== src/fpu_settings.svh ====
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// Float register file geometry
`define FP_REG_COUNT 32
`define FP_ADDR_W 5

// Single precision word
`define FP_WORD_W 32

`endif

// ==== src/fpu_isa_pkg.sv ====
`include "fpu_settings.svh"

package fpu_isa_pkg;

  localparam logic [6:0] opcode_fp = 7'b1010011;
  localparam logic [6:0] opcode_fmadd = 7'b1000011;
  localparam logic [6:0] opcode_fmsub = 7'b1000111;
  localparam logic [6:0] opcode_fnmsub = 7'b1001011;
  localparam logic [6:0] opcode_fnmadd = 7'b1001111;

  localparam logic [1:0] fmt_s = 2'b00; // Single precision

  localparam logic [4:0] funct5_sgnj = 5'b00100;
  localparam logic [4:0] funct5_minmax = 5'b00101;
  localparam logic [4:0] funct5_cmp = 5'b10100;
  localparam logic [4:0] funct5_fmv_x_w = 5'b11100; // Shared with fclass
  localparam logic [4:0] funct5_fmv_w_x = 5'b11110;

  localparam logic [2:0] funct3_sgnj = 3'b000;
  localparam logic [2:0] funct3_sgnjn = 3'b001;
  localparam logic [2:0] funct3_sgnjx = 3'b010;
  localparam logic [2:0] funct3_min = 3'b000;
  localparam logic [2:0] funct3_max = 3'b001;
  localparam logic [2:0] funct3_fle = 3'b000;
  localparam logic [2:0] funct3_flt = 3'b001;
  localparam logic [2:0] funct3_feq = 3'b010;
  localparam logic [2:0] funct3_fmv = 3'b000;
  localparam logic [2:0] funct3_fclass = 3'b001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3; // Rounding mode field
    logic [4:0] rd;
    logic [6:0] opcode;
  } fp_r_s;

  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fp_r4_s;

  typedef union packed {
    fp_r_s r;
    fp_r4_s r4;
  } fp_instr_u;

  typedef enum logic [3:0] {
    op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max, op_feq, op_flt, op_fle,
    op_fclass, op_fmv_x_w, op_fmv_w_x, op_none
  } fp_op_e;

  typedef struct packed {
    fp_op_e op;
    logic [`FP_ADDR_W-1:0] rd;
    logic [`FP_ADDR_W-1:0] rs1;
    logic [`FP_ADDR_W-1:0] rs2;
    logic fwren; // Float register write
    logic xwren; // Integer result
    logic frden1;
    logic frden2;
    logic legal;
  } fp_decode_s;

endpackage

// ==== src/fpu_data_pkg.sv ====
`include "fpu_settings.svh"

package fpu_data_pkg;

  typedef struct packed {
    logic sign;
    logic [7:0] exponent;
    logic [22:0] mantissa;
  } fp_word_s;

  localparam logic [`FP_WORD_W-1:0] fp_canon_nan = 32'h7fc0_0000;

  typedef struct packed {
    logic fwren;
    logic [`FP_ADDR_W-1:0] waddr;
    logic [`FP_WORD_W-1:0] wdata;
  } fp_wb_s;

  // Same order as the fflags bits
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_s;

  localparam logic [11:0] csr_fflags = 12'h001;
  localparam logic [11:0] csr_frm = 12'h002;
  localparam logic [11:0] csr_fcsr = 12'h003;

endpackage

// ==== src/fpu_decode.sv ====
`timescale 1ns/1ps

module fpu_decode import fpu_isa_pkg::*; (
  input fp_instr_u instr_i,
  output fp_decode_s decode_o
);

  logic fused;

  // Fused multiply-add family, recognised only to be rejected
  assign fused = instr_i.r4.opcode inside {opcode_fmadd, opcode_fmsub,
                                           opcode_fnmsub, opcode_fnmadd};

  always_comb begin
    decode_o = '0;
    decode_o.op = op_none;
    decode_o.rd = instr_i.r.rd;
    decode_o.rs1 = instr_i.r.rs1;
    decode_o.rs2 = instr_i.r.rs2;

    if (!fused && instr_i.r.opcode == opcode_fp && instr_i.r.funct7[1:0] == fmt_s) begin
      case (instr_i.r.funct7[6:2])
        funct5_sgnj: begin
          case (instr_i.r.funct3)
            funct3_sgnj: decode_o.op = op_sgnj;
            funct3_sgnjn: decode_o.op = op_sgnjn;
            funct3_sgnjx: decode_o.op = op_sgnjx;
            default: ;
          endcase
        end
        funct5_minmax: begin
          case (instr_i.r.funct3)
            funct3_min: decode_o.op = op_min;
            funct3_max: decode_o.op = op_max;
            default: ;
          endcase
        end
        funct5_cmp: begin
          case (instr_i.r.funct3)
            funct3_fle: decode_o.op = op_fle;
            funct3_flt: decode_o.op = op_flt;
            funct3_feq: decode_o.op = op_feq;
            default: ;
          endcase
        end
        funct5_fmv_x_w: begin
          case (instr_i.r.funct3)
            funct3_fmv: decode_o.op = op_fmv_x_w;
            funct3_fclass: decode_o.op = op_fclass;
            default: ;
          endcase
        end
        funct5_fmv_w_x: begin
          if (instr_i.r.funct3 == funct3_fmv) begin
            decode_o.op = op_fmv_w_x;
          end
        end
        default: ;
      endcase
    end

    case (decode_o.op)
      op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max: begin
        decode_o.fwren = 1'b1;
        decode_o.frden1 = 1'b1;
        decode_o.frden2 = 1'b1;
      end
      op_feq, op_flt, op_fle: begin
        decode_o.xwren = 1'b1;
        decode_o.frden1 = 1'b1;
        decode_o.frden2 = 1'b1;
      end
      op_fclass, op_fmv_x_w: begin
        decode_o.xwren = 1'b1;
        decode_o.frden1 = 1'b1;
      end
      op_fmv_w_x: decode_o.fwren = 1'b1; // Operand comes from xdata
      default: ;
    endcase

    decode_o.legal = (decode_o.op != op_none);
  end

endmodule

// ==== src/fpu_regfile.sv ====
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_regfile import fpu_data_pkg::*; (
  input logic clock,
  input logic [`FP_ADDR_W-1:0] raddr1_i,
  input logic [`FP_ADDR_W-1:0] raddr2_i,
  input fp_wb_s wb_i,
  output logic [`FP_WORD_W-1:0] rdata1_o,
  output logic [`FP_WORD_W-1:0] rdata2_o
);

  logic [`FP_WORD_W-1:0] regs [`FP_REG_COUNT];

  always_ff @(posedge clock) begin
    if (wb_i.fwren) begin
      regs[wb_i.waddr] <= wb_i.wdata;
    end
  end

  // Asynchronous read, write-back bypass lives in fpu_forward
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// ==== src/fpu_forward.sv ====
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_forward import fpu_data_pkg::*; (
  input logic [`FP_ADDR_W-1:0] raddr1_i,
  input logic [`FP_ADDR_W-1:0] raddr2_i,
  input logic frden1_i,
  input logic frden2_i,
  input logic [`FP_WORD_W-1:0] rdata1_i,
  input logic [`FP_WORD_W-1:0] rdata2_i,
  input fp_wb_s wb_i,
  output logic [`FP_WORD_W-1:0] data1_o,
  output logic [`FP_WORD_W-1:0] data2_o
);

  function automatic logic [`FP_WORD_W-1:0] pick(
    input logic rden,
    input logic [`FP_ADDR_W-1:0] raddr,
    input logic [`FP_WORD_W-1:0] rdata,
    input fp_wb_s wb
  );
    if (!rden) begin
      return '0;
    end else if (wb.fwren && wb.waddr == raddr) begin
      return wb.wdata; // Not yet in the register file
    end
    return rdata;
  endfunction

  assign data1_o = pick(frden1_i, raddr1_i, rdata1_i, wb_i);
  assign data2_o = pick(frden2_i, raddr2_i, rdata2_i, wb_i);

endmodule

// ==== src/fpu_csr.sv ====
`timescale 1ns/1ps

module fpu_csr import fpu_data_pkg::*; (
  input logic clock,
  input logic reset,
  input logic csr_we_i,
  input logic [11:0] csr_addr_i,
  input logic [31:0] csr_wdata_i,
  input fp_flags_s flags_i,
  output logic [31:0] csr_rdata_o,
  output logic csr_hit_o
);

  logic [2:0] frm;
  logic [4:0] fflags;
  logic [4:0] fflags_wr;

  // Value after a port write, before accrual
  always_comb begin
    fflags_wr = fflags;
    if (csr_we_i && (csr_addr_i == csr_fflags || csr_addr_i == csr_fcsr)) begin
      fflags_wr = csr_wdata_i[4:0];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      frm <= '0;
      fflags <= '0;
    end else begin
      fflags <= fflags_wr | flags_i; // Accrue on top of the write
      if (csr_we_i) begin
        case (csr_addr_i)
          csr_frm: frm <= csr_wdata_i[2:0];
          csr_fcsr: frm <= csr_wdata_i[7:5];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    csr_rdata_o = '0;
    csr_hit_o = 1'b1;
    case (csr_addr_i)
      csr_fflags: csr_rdata_o = {27'b0, fflags};
      csr_frm: csr_rdata_o = {29'b0, frm};
      csr_fcsr: csr_rdata_o = {24'b0, frm, fflags};
      default: csr_hit_o = 1'b0;
    endcase
  end

endmodule

// ==== src/fpu_misc_exec.sv ====
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_misc_exec import fpu_isa_pkg::*, fpu_data_pkg::*; (
  input fp_op_e op_i,
  input fp_word_s a_i,
  input fp_word_s b_i,
  input logic [`FP_WORD_W-1:0] xdata_i,
  output logic [`FP_WORD_W-1:0] fresult_o,
  output logic [`FP_WORD_W-1:0] xresult_o,
  output fp_flags_s flags_o
);

  logic [9:0] class_a;
  logic [9:0] class_b;
  logic a_nan;
  logic b_nan;
  logic any_snan;
  logic both_zero;
  logic mag_lt;
  logic mag_gt;
  logic ord_lt;
  logic cmp_lt;
  logic cmp_eq;

  // RISC-V fclass encoding, bit 0 is -inf up to bit 9 quiet NaN
  function automatic logic [9:0] classify(input fp_word_s x);
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    logic [9:0] c;
    exp_max = &x.exponent;
    exp_zero = ~|x.exponent;
    man_zero = ~|x.mantissa;
    c = '0;
    if (exp_max && man_zero) begin
      c[x.sign ? 0 : 7] = 1'b1;
    end else if (exp_max) begin
      c[x.mantissa[22] ? 9 : 8] = 1'b1;
    end else if (exp_zero && man_zero) begin
      c[x.sign ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      c[x.sign ? 2 : 5] = 1'b1;
    end else begin
      c[x.sign ? 1 : 6] = 1'b1;
    end
    return c;
  endfunction

  assign class_a = classify(a_i);
  assign class_b = classify(b_i);
  assign a_nan = class_a[8] | class_a[9];
  assign b_nan = class_b[8] | class_b[9];
  assign any_snan = class_a[8] | class_b[8];
  assign both_zero = (class_a[3] | class_a[4]) & (class_b[3] | class_b[4]);

  assign mag_lt = {a_i.exponent, a_i.mantissa} < {b_i.exponent, b_i.mantissa};
  assign mag_gt = {b_i.exponent, b_i.mantissa} < {a_i.exponent, a_i.mantissa};
  // Total order over non-NaN values, -0 below +0
  assign ord_lt = (a_i.sign != b_i.sign) ? a_i.sign : (a_i.sign ? mag_gt : mag_lt);
  assign cmp_lt = ord_lt & ~both_zero;
  assign cmp_eq = (a_i == b_i) | both_zero;

  always_comb begin
    fresult_o = '0;
    xresult_o = '0;
    flags_o = '0;
    case (op_i)
      op_sgnj: fresult_o = {b_i.sign, a_i.exponent, a_i.mantissa};
      op_sgnjn: fresult_o = {~b_i.sign, a_i.exponent, a_i.mantissa};
      op_sgnjx: fresult_o = {a_i.sign ^ b_i.sign, a_i.exponent, a_i.mantissa};
      op_min, op_max: begin
        flags_o.nv = any_snan;
        if (a_nan && b_nan) begin
          fresult_o = fp_canon_nan;
        end else if (a_nan) begin
          fresult_o = b_i;
        end else if (b_nan) begin
          fresult_o = a_i;
        end else if (op_i == op_min) begin
          fresult_o = ord_lt ? a_i : b_i;
        end else begin
          fresult_o = ord_lt ? b_i : a_i;
        end
      end
      op_feq: begin
        flags_o.nv = any_snan; // Quiet compare
        xresult_o[0] = ~(a_nan | b_nan) & cmp_eq;
      end
      op_flt: begin
        flags_o.nv = a_nan | b_nan;
        xresult_o[0] = ~(a_nan | b_nan) & cmp_lt;
      end
      op_fle: begin
        flags_o.nv = a_nan | b_nan;
        xresult_o[0] = ~(a_nan | b_nan) & (cmp_lt | cmp_eq);
      end
      op_fclass: xresult_o = {22'b0, class_a};
      op_fmv_x_w: xresult_o = a_i;
      op_fmv_w_x: fresult_o = xdata_i;
      default: ;
    endcase
  end

endmodule

// ==== src/fpu_unit.sv ====
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_unit import fpu_isa_pkg::*, fpu_data_pkg::*; (
  input logic clock,
  input logic reset,
  input logic instr_valid_i,
  input fp_instr_u instr_i,
  input logic [`FP_WORD_W-1:0] xdata_i,
  output logic xwren_o,
  output logic [`FP_WORD_W-1:0] xdata_o,
  output logic illegal_o,
  input logic csr_we_i,
  input logic [11:0] csr_addr_i,
  input logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,
  output logic csr_hit_o
);

  fp_decode_s decode;
  logic [`FP_WORD_W-1:0] rdata1;
  logic [`FP_WORD_W-1:0] rdata2;
  logic [`FP_WORD_W-1:0] data1;
  logic [`FP_WORD_W-1:0] data2;
  logic [`FP_WORD_W-1:0] fresult;
  logic [`FP_WORD_W-1:0] xresult;
  fp_flags_s flags;
  fp_wb_s wb_q;
  fp_flags_s flags_q;

  fpu_decode u_decode (
    .instr_i (instr_i),
    .decode_o (decode)
  );

  fpu_regfile u_regfile (
    .clock (clock),
    .raddr1_i (decode.rs1),
    .raddr2_i (decode.rs2),
    .wb_i (wb_q),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  fpu_forward u_forward (
    .raddr1_i (decode.rs1),
    .raddr2_i (decode.rs2),
    .frden1_i (decode.frden1),
    .frden2_i (decode.frden2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .wb_i (wb_q),
    .data1_o (data1),
    .data2_o (data2)
  );

  fpu_misc_exec u_exec (
    .op_i (decode.op),
    .a_i (data1),
    .b_i (data2),
    .xdata_i (xdata_i),
    .fresult_o (fresult),
    .xresult_o (xresult),
    .flags_o (flags)
  );

  // Execute to write-back boundary
  always_ff @(posedge clock) begin
    wb_q.waddr <= decode.rd;
    wb_q.wdata <= fresult;
    xdata_o <= xresult;
    if (!reset) begin
      wb_q.fwren <= 1'b0;
      xwren_o <= 1'b0;
      illegal_o <= 1'b0;
      flags_q <= '0;
    end else begin
      wb_q.fwren <= instr_valid_i & decode.legal & decode.fwren;
      xwren_o <= instr_valid_i & decode.legal & decode.xwren;
      illegal_o <= instr_valid_i & ~decode.legal;
      flags_q <= instr_valid_i ? flags : '0; // Idle cycles accrue nothing
    end
  end

  fpu_csr u_csr (
    .clock (clock),
    .reset (reset),
    .csr_we_i (csr_we_i),
    .csr_addr_i (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .flags_i (flags_q),
    .csr_rdata_o (csr_rdata_o),
    .csr_hit_o (csr_hit_o)
  );

endmodule

// ==== verification/fpu_unit_tb.sv ====
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_unit_tb import fpu_isa_pkg::*, fpu_data_pkg::*; ();

  localparam int n_sgnj = 20;
  localparam int n_cmp = 40;
  localparam int n_class = 30;
  localparam int total_cycles = 8 + 20 + 64 + 2 * n_sgnj + 24 + 2 * n_cmp + 2 * n_class + 48;
  localparam int max_cycles = 2 * total_cycles + 100;
  // Illegal {funct5, funct3} pairs: fadd, fdiv, fcvt, then unused variants
  localparam logic [7:0] bad_codes [8] = '{8'b00000_000, 8'b00011_000, 8'b11000_000,
                                           8'b00100_011, 8'b00101_010, 8'b10100_011,
                                           8'b11100_010, 8'b11110_001};

  typedef struct packed {
    logic xwren;
    logic illegal;
    logic [31:0] xdata;
  } expect_s;

  typedef struct packed {
    logic [31:0] f;
    logic [31:0] x;
    logic nv;
  } result_s;

  logic clock;
  logic reset;
  logic instr_valid_i;
  fp_instr_u instr_i;
  logic [31:0] xdata_i;
  logic xwren_o;
  logic [31:0] xdata_o;
  logic illegal_o;
  logic csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic csr_hit_o;

  logic [31:0] lfsr;
  logic [31:0] shadow [`FP_REG_COUNT];
  logic [2:0] exp_frm;
  logic [4:0] exp_fflags;
  expect_s exp_q [$];
  expect_s pending;
  logic pending_valid = 1'b0;
  int n_checks = 0;
  int n_errors = 0;
  int cycle_count;

  fpu_unit UUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    logic [2:0] sel;
    r = rand_bits(32);
    sel = 3'(rand_bits(3));
    case (sel)
      3'd0: return {r[31], 31'b0};
      3'd1: return {r[31], 8'hff, 23'b0};
      3'd2: return {r[31], 8'hff, 1'b1, r[21:0]}; // Quiet NaN
      3'd3: return {r[31], 8'hff, 2'b01, r[20:0]}; // Signalling NaN
      3'd4: return {r[31], 8'h00, r[22:1], 1'b1}; // Subnormal
      default: return r;
    endcase
  endfunction

  function automatic logic [31:0] order_key(input logic [31:0] v);
    return v[31] ? ~v : {1'b1, v[30:0]};
  endfunction

  function automatic logic [9:0] class_of(input logic [31:0] v);
    int idx;
    if (v[30:23] == 8'hff) begin
      idx = (v[22:0] == 23'd0) ? (v[31] ? 0 : 7) : (v[22] ? 9 : 8);
    end else if (v[30:23] == 8'h00) begin
      idx = (v[22:0] == 23'd0) ? (v[31] ? 3 : 4) : (v[31] ? 2 : 5);
    end else begin
      idx = v[31] ? 1 : 6;
    end
    return 10'b1 << idx;
  endfunction

  function automatic result_s ref_exec(input fp_op_e op, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] x);
    result_s r;
    logic a_nan;
    logic b_nan;
    logic a_snan;
    logic b_snan;
    logic both_zero;
    logic lt;
    logic eq;
    r = '0;
    a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    a_snan = a_nan && !a[22];
    b_snan = b_nan && !b[22];
    both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    lt = order_key(a) < order_key(b); // -0 orders below +0
    eq = (a == b) || both_zero;
    case (op)
      op_sgnj: r.f = {b[31], a[30:0]};
      op_sgnjn: r.f = {~b[31], a[30:0]};
      op_sgnjx: r.f = {a[31] ^ b[31], a[30:0]};
      op_min, op_max: begin
        r.nv = a_snan | b_snan;
        if (a_nan && b_nan) r.f = 32'h7fc0_0000;
        else if (a_nan) r.f = b;
        else if (b_nan) r.f = a;
        else r.f = ((op == op_min) == lt) ? a : b;
      end
      op_feq: begin
        r.nv = a_snan | b_snan;
        r.x[0] = !(a_nan || b_nan) && eq;
      end
      op_flt: begin
        r.nv = a_nan | b_nan;
        r.x[0] = !(a_nan || b_nan) && lt && !both_zero;
      end
      op_fle: begin
        r.nv = a_nan | b_nan;
        r.x[0] = !(a_nan || b_nan) && (lt || eq);
      end
      op_fclass: r.x = {22'b0, class_of(a)};
      op_fmv_x_w: r.x = a;
      op_fmv_w_x: r.f = x;
      default: ;
    endcase
    return r;
  endfunction

  function automatic fp_instr_u encode(input fp_op_e op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
    fp_instr_u w;
    logic [7:0] code;
    case (op)
      op_sgnj: code = {funct5_sgnj, funct3_sgnj};
      op_sgnjn: code = {funct5_sgnj, funct3_sgnjn};
      op_sgnjx: code = {funct5_sgnj, funct3_sgnjx};
      op_min: code = {funct5_minmax, funct3_min};
      op_max: code = {funct5_minmax, funct3_max};
      op_feq: code = {funct5_cmp, funct3_feq};
      op_flt: code = {funct5_cmp, funct3_flt};
      op_fle: code = {funct5_cmp, funct3_fle};
      op_fclass: code = {funct5_fmv_x_w, funct3_fclass};
      op_fmv_x_w: code = {funct5_fmv_x_w, funct3_fmv};
      default: code = {funct5_fmv_w_x, funct3_fmv};
    endcase
    w.r.funct7 = {code[7:3], fmt_s};
    w.r.rs2 = rs2;
    w.r.rs1 = rs1;
    w.r.funct3 = code[2:0];
    w.r.rd = rd;
    w.r.opcode = opcode_fp;
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // op_none marks a word that must be rejected
  task automatic issue(input fp_instr_u w, input fp_op_e op, input logic [31:0] x);
    result_s r;
    expect_s e;
    @(posedge clock);
    instr_valid_i <= 1'b1;
    instr_i <= w;
    xdata_i <= x;
    csr_we_i <= 1'b0;
    r = ref_exec(op, shadow[w.r.rs1], shadow[w.r.rs2], x);
    e.illegal = (op == op_none);
    e.xwren = op inside {op_feq, op_flt, op_fle, op_fclass, op_fmv_x_w};
    e.xdata = r.x;
    if (op inside {op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max, op_fmv_w_x}) begin
      shadow[w.r.rd] = r.f;
    end
    exp_fflags = exp_fflags | {r.nv, 4'b0};
    exp_q.push_back(e);
  endtask

  // Float results are read back right away, through forwarding
  task automatic execute(input fp_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [31:0] x);
    issue(encode(op, rd, rs1, rs2), op, x);
    if (op inside {op_sgnj, op_sgnjn, op_sgnjx, op_min, op_max, op_fmv_w_x}) begin
      issue(encode(op_fmv_x_w, 5'd0, rd, 5'd0), op_fmv_x_w, 32'd0);
    end
  endtask

  task automatic idle();
    @(posedge clock);
    instr_valid_i <= 1'b0;
    csr_we_i <= 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clock);
    instr_valid_i <= 1'b0;
    csr_we_i <= 1'b1;
    csr_addr_i <= addr;
    csr_wdata_i <= data;
    if (addr == csr_fflags || addr == csr_fcsr) exp_fflags = data[4:0];
    if (addr == csr_frm) exp_frm = data[2:0];
    if (addr == csr_fcsr) exp_frm = data[7:5];
  endtask

  task automatic csr_check(input logic [11:0] addr);
    logic [31:0] want;
    logic hit;
    want = '0;
    hit = 1'b1;
    case (addr)
      csr_fflags: want = {27'b0, exp_fflags};
      csr_frm: want = {29'b0, exp_frm};
      csr_fcsr: want = {24'b0, exp_frm, exp_fflags};
      default: hit = 1'b0;
    endcase
    @(posedge clock);
    instr_valid_i <= 1'b0;
    csr_we_i <= 1'b0;
    csr_addr_i <= addr;
    @(negedge clock);
    check("csr_rdata_o", csr_rdata_o, want);
    check("csr_hit_o", 32'(csr_hit_o), 32'(hit));
  endtask

  // Results show up one edge after issue
  always @(negedge clock) begin
    if (pending_valid) begin
      check("xwren_o", 32'(xwren_o), 32'(pending.xwren));
      check("illegal_o", 32'(illegal_o), 32'(pending.illegal));
      if (pending.xwren) check("xdata_o", xdata_o, pending.xdata);
    end else if (reset) begin
      check("xwren_o", 32'(xwren_o), 32'd0);
      check("illegal_o", 32'(illegal_o), 32'd0);
    end
    pending_valid = 1'b0;
    if (exp_q.size() > 0) begin
      pending = exp_q.pop_front();
      pending_valid = 1'b1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", max_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    fp_instr_u w;
    fp_op_e op;
    lfsr = 32'hcea8_1af3;
    exp_frm = '0;
    exp_fflags = '0;
    reset = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    xdata_i = '0;
    csr_we_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    repeat (8) @(posedge clock);
    reset <= 1'b1;

    csr_check(csr_fflags);
    csr_check(csr_frm);
    csr_check(csr_fcsr);
    csr_write(csr_frm, 32'hffff_fffd);
    csr_check(csr_frm);
    csr_check(csr_fcsr);
    csr_write(csr_fflags, 32'h0000_0035);
    csr_check(csr_fflags);
    csr_write(csr_fcsr, 32'h0000_00e6);
    csr_check(csr_frm);
    csr_check(csr_fflags);
    csr_check(csr_fcsr);
    csr_check(12'h004); // Unknown address
    csr_check(12'hc00);
    csr_write(csr_fcsr, 32'd0);

    for (int i = 0; i < 32; i++) begin
      execute(op_fmv_w_x, 5'(i), 5'd0, 5'd0, rand_bits(32));
    end

    for (int i = 0; i < n_sgnj; i++) begin
      op = fp_op_e'(4'(rand_bits(2) % 3));
      execute(op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)), 32'd0);
    end

    idle();
    idle();
    csr_write(csr_fflags, 32'd0);
    for (int i = 0; i < 16; i++) begin
      issue(encode(op_fmv_w_x, 5'(i), 5'd0, 5'd0), op_fmv_w_x, pick_operand());
    end
    for (int i = 0; i < n_cmp; i++) begin
      op = fp_op_e'(4'(3 + rand_bits(3) % 5));
      execute(op, {1'b1, 4'(rand_bits(4))}, 5'(rand_bits(4)), 5'(rand_bits(4)), 32'd0);
    end
    idle();
    idle();
    csr_check(csr_fflags);

    for (int i = 0; i < n_class; i++) begin
      issue(encode(op_fmv_w_x, 5'd1, 5'd0, 5'd0), op_fmv_w_x, pick_operand());
      execute(op_fclass, 5'd0, 5'd1, 5'd0, 32'd0);
    end

    for (int i = 0; i < 4; i++) begin
      w = rand_bits(32);
      w.r4.fmt = fmt_s;
      w.r4.opcode = (i == 0) ? opcode_fmadd : (i == 1) ? opcode_fmsub :
                    (i == 2) ? opcode_fnmsub : opcode_fnmadd;
      issue(w, op_none, 32'd0);
    end
    for (int i = 0; i < 8; i++) begin
      w = encode(op_sgnj, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
      w.r.funct7 = {bad_codes[i][7:3], fmt_s};
      w.r.funct3 = bad_codes[i][2:0];
      issue(w, op_none, rand_bits(32));
    end
    for (int i = 0; i < 32; i++) begin
      execute(op_fmv_x_w, 5'd0, 5'(i), 5'd0, 32'd0);
    end

    idle();
    idle();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== fpu_unit.f ====
+incdir+src
src/fpu_isa_pkg.sv
src/fpu_data_pkg.sv
src/fpu_decode.sv
src/fpu_regfile.sv
src/fpu_forward.sv
src/fpu_csr.sv
src/fpu_misc_exec.sv
src/fpu_unit.sv
verification/fpu_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fpu_unit_tb
FILELIST ?= fpu_unit.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
